/* include/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// address map of the memory interconnect, each window is [base, top)
`define RAM_BASE 32'h0000_0000
`define RAM_TOP 32'h0000_1000

`define CLINT_BASE 32'h0200_0000
`define CLINT_TOP 32'h0200_C000

// scratch ram depth in 32-bit words, fills the whole ram window
`define RAM_WORDS 1024

// clint register offsets relative to CLINT_BASE
`define CLINT_MSIP 32'h0000_0000
`define CLINT_MTIMECMP 32'h0000_4000 // high word at plus 4
`define CLINT_MTIME 32'h0000_BFF8 // high word at plus 4

// reset value of mtimecmp keeps mtip low until software sets it
`define MTIMECMP_RESET 64'hFFFF_FFFF_FFFF_FFFF

`endif

/* hw/soc_pkg.sv */
package soc_pkg;

  typedef logic [31:0] word_t; // bus address or data word
  typedef logic [3:0] strb_t; // all zero means a read

  // target picked by the address decoder
  typedef enum logic [1:0] {
    target_ram,
    target_clint,
    target_none
  } target_e;

  // replaces the strobed bytes of a stored word with the bytes of a bus write
  function automatic word_t merge_bytes(word_t old_word, word_t new_word, strb_t strb);
    word_t merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

/* hw/mem_bus_if.sv */
// one valid/ready memory bus link between the decoder and a target
interface mem_bus_if;

  logic valid;
  logic instr; // request is an instruction fetch
  soc_pkg::word_t addr; // already rebased to the target window
  soc_pkg::word_t wdata;
  soc_pkg::strb_t wstrb;

  soc_pkg::word_t rdata; // valid while ready is high
  logic ready; // one pulse per request

  modport requester (
    output valid,
    output instr,
    output addr,
    output wdata,
    output wstrb,
    input rdata,
    input ready
  );

  modport target (
    input valid,
    input instr,
    input addr,
    input wdata,
    input wstrb,
    output rdata,
    output ready
  );

endinterface

/* hw/bus_decode.sv */
`include "soc_config.svh"

module bus_decode (
  input logic mem_valid,
  input logic mem_instr,
  input soc_pkg::word_t mem_addr,
  input soc_pkg::word_t mem_wdata,
  input soc_pkg::strb_t mem_wstrb,
  mem_bus_if.requester ram_bus,
  mem_bus_if.requester clint_bus,
  output logic decode_error
);

  soc_pkg::target_e target;
  soc_pkg::word_t ram_offset;
  soc_pkg::word_t clint_offset;
  logic in_ram;
  logic in_clint;

  // offsets into each window, an address below the base wraps to a large value
  assign ram_offset = mem_addr - `RAM_BASE;
  assign clint_offset = mem_addr - `CLINT_BASE;

  assign in_ram = ram_offset < (`RAM_TOP - `RAM_BASE);
  assign in_clint = clint_offset < (`CLINT_TOP - `CLINT_BASE);

  always_comb begin
    target = soc_pkg::target_none;
    if (in_ram) begin
      target = soc_pkg::target_ram;
    end else if (in_clint && !mem_instr) begin
      // code is never fetched from timer registers
      target = soc_pkg::target_clint;
    end
  end

  always_comb begin
    ram_bus.valid = mem_valid && (target == soc_pkg::target_ram);
    ram_bus.instr = mem_instr;
    ram_bus.addr = ram_offset;
    ram_bus.wdata = mem_wdata;
    ram_bus.wstrb = mem_wstrb;
  end

  always_comb begin
    clint_bus.valid = mem_valid && (target == soc_pkg::target_clint);
    clint_bus.instr = mem_instr;
    clint_bus.addr = clint_offset;
    clint_bus.wdata = mem_wdata;
    clint_bus.wstrb = mem_wstrb;
  end

  // held high for as long as the bad request stays on the bus
  assign decode_error = mem_valid && (target == soc_pkg::target_none);

endmodule

/* hw/data_ram.sv */
`include "soc_config.svh"

module data_ram (
  input logic clock,
  input logic reset,
  mem_bus_if.target bus
);

  localparam int index_bits = $clog2(`RAM_WORDS);

  soc_pkg::word_t ram [`RAM_WORDS];
  logic [index_bits-1:0] index;
  logic access;
  logic write;

  assign index = bus.addr[index_bits+1:2]; // word index, byte lanes come from the strobes

  // a request already answered is still on the bus during its ready cycle
  assign access = bus.valid && !bus.ready;

  // instruction fetches only ever read
  assign write = access && !bus.instr && (bus.wstrb != '0);

  always_ff @(posedge clock) begin
    if (access) begin
      bus.rdata <= ram[index]; // old word, taken before the write below lands
    end
    if (write) begin
      ram[index] <= soc_pkg::merge_bytes(ram[index], bus.wdata, bus.wstrb);
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= access;
    end
  end

endmodule

/* hw/clint.sv */
`include "soc_config.svh"

module clint (
  input logic clock,
  input logic reset,
  mem_bus_if.target bus,
  output logic msip,
  output logic mtip
);

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic msip_reg;
  logic access;
  logic write;
  soc_pkg::word_t read_word;

  assign access = bus.valid && !bus.ready;
  assign write = access && (bus.wstrb != '0);

  always_comb begin
    case (bus.addr)
      `CLINT_MSIP: read_word = {31'b0, msip_reg};
      `CLINT_MTIMECMP: read_word = mtimecmp[31:0];
      (`CLINT_MTIMECMP + 32'h4): read_word = mtimecmp[63:32];
      `CLINT_MTIME: read_word = mtime[31:0];
      (`CLINT_MTIME + 32'h4): read_word = mtime[63:32];
      default: read_word = '0; // holes in the window read as zero
    endcase
  end

  always_ff @(posedge clock) begin
    if (access) begin
      bus.rdata <= read_word;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      mtime <= '0;
      mtimecmp <= `MTIMECMP_RESET;
      msip_reg <= 1'b0;
      msip <= 1'b0;
      mtip <= 1'b0;
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= access;
      msip <= msip_reg; // port lags the register by one cycle
      mtip <= mtime >= mtimecmp;
      mtime <= mtime + 64'd1;

      // a write to mtime replaces this cycle's increment
      if (write) begin
        case (bus.addr)
          `CLINT_MSIP: begin
            if (bus.wstrb[0]) begin
              msip_reg <= bus.wdata[0];
            end
          end
          `CLINT_MTIMECMP: begin
            mtimecmp[31:0] <= soc_pkg::merge_bytes(mtimecmp[31:0], bus.wdata, bus.wstrb);
          end
          (`CLINT_MTIMECMP + 32'h4): begin
            mtimecmp[63:32] <= soc_pkg::merge_bytes(mtimecmp[63:32], bus.wdata, bus.wstrb);
          end
          `CLINT_MTIME: begin
            mtime <= {mtime[63:32], soc_pkg::merge_bytes(mtime[31:0], bus.wdata, bus.wstrb)};
          end
          (`CLINT_MTIME + 32'h4): begin
            mtime <= {soc_pkg::merge_bytes(mtime[63:32], bus.wdata, bus.wstrb), mtime[31:0]};
          end
          default: begin
            // writes to unused offsets are dropped
          end
        endcase
      end
    end
  end

endmodule

/* hw/bus_response.sv */
module bus_response (
  input logic clock,
  input logic reset,
  mem_bus_if.target ram_bus, // only ready and rdata are looked at
  mem_bus_if.target clint_bus,
  input logic decode_error,
  output soc_pkg::word_t mem_rdata,
  output logic mem_error,
  output logic mem_ready
);

  soc_pkg::target_e source;
  logic error_ready;

  // one error pulse per bad request, like the ready of a real target
  always_ff @(posedge clock) begin
    if (!reset) begin
      error_ready <= 1'b0;
    end else begin
      error_ready <= decode_error && !error_ready;
    end
  end

  always_comb begin
    if (ram_bus.ready) begin
      source = soc_pkg::target_ram;
    end else if (clint_bus.ready) begin
      source = soc_pkg::target_clint;
    end else begin
      source = soc_pkg::target_none;
    end
  end

  always_comb begin
    case (source)
      soc_pkg::target_ram: mem_rdata = ram_bus.rdata;
      soc_pkg::target_clint: mem_rdata = clint_bus.rdata;
      default: mem_rdata = '0; // error responses carry zero data
    endcase
  end

  assign mem_error = error_ready;
  assign mem_ready = (source != soc_pkg::target_none) || error_ready;

endmodule

/* hw/soc_bus.sv */
module soc_bus (
  input logic clock,
  input logic reset,
  input logic mem_valid,
  input logic mem_instr,
  input soc_pkg::word_t mem_addr,
  input soc_pkg::word_t mem_wdata,
  input soc_pkg::strb_t mem_wstrb,
  output soc_pkg::word_t mem_rdata,
  output logic mem_error,
  output logic mem_ready,
  output logic msip,
  output logic mtip
);

  logic decode_error;

  mem_bus_if ram_bus ();
  mem_bus_if clint_bus ();

  // decode stage
  bus_decode i_bus_decode (
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_addr (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .ram_bus (ram_bus.requester),
    .clint_bus (clint_bus.requester),
    .decode_error (decode_error)
  );

  // execute stage, one target per link
  data_ram i_data_ram (
    .clock (clock),
    .reset (reset),
    .bus (ram_bus.target)
  );

  clint i_clint (
    .clock (clock),
    .reset (reset),
    .bus (clint_bus.target),
    .msip (msip),
    .mtip (mtip)
  );

  // result stage
  bus_response i_bus_response (
    .clock (clock),
    .reset (reset),
    .ram_bus (ram_bus.target),
    .clint_bus (clint_bus.target),
    .decode_error (decode_error),
    .mem_rdata (mem_rdata),
    .mem_error (mem_error),
    .mem_ready (mem_ready)
  );

endmodule

/* bench/clock_gen.sv */
module clock_gen (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock; // 4 ns period
  end

  initial begin
    reset = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b1; // released on a falling edge like every other input
  end

endmodule

/* bench/soc_bus_asserts.sv */
module soc_bus_asserts (
  input logic clock,
  input logic reset,
  input logic mem_valid,
  input logic mem_ready,
  input logic mem_error
);
  timeunit 1ns;
  timeprecision 1ps;

  ready_one_cycle: assert property (@(posedge clock) disable iff (!reset)
    mem_ready |=> !mem_ready)
    else $error("mem_ready held high for more than one cycle");

  // a request not yet answered gets its response in the very next cycle
  ready_after_valid: assert property (@(posedge clock) disable iff (!reset)
    mem_valid && !mem_ready |=> mem_ready)
    else $error("no response one cycle after a new request");

  error_with_ready: assert property (@(posedge clock) disable iff (!reset)
    mem_error |-> mem_ready)
    else $error("mem_error raised without mem_ready");

  no_stray_response: assert property (@(posedge clock) disable iff (!reset)
    mem_ready |-> $past(mem_valid))
    else $error("response without a pending request");

  quiet_after_reset: assert property (@(posedge clock)
    $rose(reset) |-> !mem_ready && !mem_error)
    else $error("response flags high in the cycle after reset");

endmodule

bind soc_bus soc_bus_asserts i_soc_bus_asserts (
  .clock (clock),
  .reset (reset),
  .mem_valid (mem_valid),
  .mem_ready (mem_ready),
  .mem_error (mem_error)
);

/* bench/soc_bus_tb.sv */
`include "soc_config.svh"

module soc_bus_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned seed = 24;
  localparam int random_ops = 600;
  localparam int test_count = `RAM_WORDS + random_ops + 40; // preload, traffic, clint steps
  localparam int timeout_ns = test_count * 4 * 4 + 400;

  logic clock, reset;
  logic mem_valid, mem_instr, mem_error, mem_ready, msip, mtip;
  soc_pkg::word_t mem_addr, mem_wdata, mem_rdata;
  soc_pkg::strb_t mem_wstrb;

  soc_pkg::word_t ram_model [`RAM_WORDS];
  logic msip_model;
  logic [63:0] mtimecmp_model;
  soc_pkg::word_t rdata; // response of the last transfer
  logic error_flag;

  clock_gen i_clock_gen (.*);
  soc_bus i_soc_bus (.*);

  task automatic compare_word(input soc_pkg::word_t actual, input soc_pkg::word_t expected,
                              input string what);
    if (actual !== expected) begin
      $display("FAIL at %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1, "stopped at the first failed check");
    end
  endtask

  task automatic compare_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("FAIL at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1, "stopped at the first failed check");
    end
  endtask

  // one request, its response exactly one cycle later, then an idle cycle
  task automatic bus_transfer(input logic instr, input soc_pkg::word_t addr,
                              input soc_pkg::word_t wdata, input soc_pkg::strb_t wstrb);
    mem_valid = 1'b1;
    mem_instr = instr;
    mem_addr = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    @(posedge clock);
    @(negedge clock);
    compare_flag(mem_ready, 1'b1, "mem_ready one cycle after the request");
    rdata = mem_rdata;
    error_flag = mem_error;
    mem_valid = 1'b0;
    mem_wstrb = '0;
    @(posedge clock);
    @(negedge clock);
  endtask

  task automatic ram_access(input logic instr, input int unsigned index,
                            input soc_pkg::word_t data, input soc_pkg::strb_t strb);
    soc_pkg::word_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    bus_transfer(instr, `RAM_BASE + (index << 2), data, strb);
    compare_flag(error_flag, 1'b0, "mem_error on a ram access");
    compare_word(rdata, ram_model[index], "ram read data"); // word as it was before the access
    if (!instr) begin
      ram_model[index] = (ram_model[index] & ~mask) | (data & mask);
    end
  endtask

  task automatic bad_access(input logic instr, input soc_pkg::word_t addr);
    bus_transfer(instr, addr, $urandom, soc_pkg::strb_t'($urandom));
    compare_flag(error_flag, 1'b1, "mem_error on a bad access");
    compare_word(rdata, '0, "read data of an error response");
  endtask

  task automatic clint_access(input soc_pkg::word_t offset, input soc_pkg::word_t data,
                              input soc_pkg::strb_t strb);
    bus_transfer(1'b0, `CLINT_BASE + offset, data, strb);
    compare_flag(error_flag, 1'b0, "mem_error on a clint access");
    if (strb == 4'hF) begin
      case (offset)
        `CLINT_MSIP: msip_model = data[0];
        `CLINT_MTIMECMP: mtimecmp_model[31:0] = data;
        `CLINT_MTIMECMP + 32'h4: mtimecmp_model[63:32] = data;
        default: ;
      endcase
    end
  endtask

  task automatic random_traffic();
    int unsigned op;
    int unsigned index;
    soc_pkg::word_t addr;
    for (int n = 0; n < random_ops; n++) begin
      op = $urandom % 10;
      index = $urandom % `RAM_WORDS;
      addr = $urandom & 32'hFFFF_FFFC;
      case (op)
        0, 1, 2, 3: ram_access(1'b0, index, $urandom, soc_pkg::strb_t'($urandom));
        4, 5: ram_access(1'b0, index, '0, '0);
        6: ram_access(1'b1, index, $urandom, soc_pkg::strb_t'($urandom));
        7: bad_access($urandom % 2 == 1, `RAM_TOP + (index << 2)); // just past the ram
        8: begin
          while ((addr >= `RAM_BASE && addr < `RAM_TOP) ||
                 (addr >= `CLINT_BASE && addr < `CLINT_TOP)) begin
            addr = $urandom & 32'hFFFF_FFFC;
          end
          bad_access($urandom % 2 == 1, addr);
        end
        default: bad_access(1'b1, `CLINT_BASE + (addr % (`CLINT_TOP - `CLINT_BASE)));
      endcase
    end
  endtask

  initial begin
    soc_pkg::word_t first;
    soc_pkg::word_t value;
    void'($urandom(seed));
    mem_valid = 1'b0;
    mem_instr = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    msip_model = 1'b0;
    mtimecmp_model = '1; // compare register comes out of reset as all ones
    @(posedge reset);
    @(negedge clock);
    compare_flag(mem_ready, 1'b0, "mem_ready after reset");
    compare_flag(mem_error, 1'b0, "mem_error after reset");
    compare_flag(msip, 1'b0, "msip after reset");
    compare_flag(mtip, 1'b0, "mtip after reset");

    // every ram word starts with a value that depends on its whole address
    for (int i = 0; i < `RAM_WORDS; i++) begin
      value = `RAM_BASE + (i << 2);
      ram_model[i] = {value[15:0], value[31:16]} ^ ~value;
      bus_transfer(1'b0, value, ram_model[i], 4'hF);
      compare_flag(error_flag, 1'b0, "mem_error during the ram preload");
    end
    random_traffic();

    for (int i = 0; i < 4; i++) begin
      value = $urandom;
      value[0] = (i % 2 == 0); // set and clear in turn
      clint_access(`CLINT_MSIP, value, 4'hF);
      compare_flag(msip, msip_model, "msip port after a write");
      clint_access(`CLINT_MSIP, '0, '0);
      compare_word(rdata, {31'b0, msip_model}, "msip register");
    end

    // two mtime reads are one two-cycle transfer apart
    clint_access(`CLINT_MTIME, '0, '0);
    first = rdata;
    clint_access(`CLINT_MTIME, '0, '0);
    compare_word(rdata, first + 32'd2, "second read of mtime low");
    value = rdata + 32'd1_000_000;
    clint_access(`CLINT_MTIMECMP + 32'h4, 32'h0, 4'hF);
    clint_access(`CLINT_MTIMECMP, value, 4'hF);
    compare_flag(mtip, 1'b0, "mtip with mtimecmp far ahead");
    clint_access(`CLINT_MTIMECMP, '0, '0);
    compare_word(rdata, mtimecmp_model[31:0], "mtimecmp low");
    clint_access(`CLINT_MTIMECMP + 32'h4, '0, '0);
    compare_word(rdata, mtimecmp_model[63:32], "mtimecmp high");
    clint_access(`CLINT_MTIMECMP, 32'h0, 4'hF);
    compare_flag(mtip, 1'b1, "mtip with mtimecmp at zero");

    $display("Test OK");
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("timeout after %0d ns, the requests did not all complete", timeout_ns);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* verilog.f */
+incdir+include
hw/soc_pkg.sv
hw/mem_bus_if.sv
hw/bus_decode.sv
hw/data_ram.sv
hw/clint.sv
hw/bus_response.sv
hw/soc_bus.sv
bench/clock_gen.sv
bench/soc_bus_asserts.sv
bench/soc_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with verilator, runs it and looks for the pass line in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module soc_bus_tb \
  -Mdir obj_dir -f verilog.f || { echo "verilator build failed"; exit 1; }
output=$(./obj_dir/Vsoc_bus_tb 2>&1)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "Test OK" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
